// ==== tb/cpu_testdata.txt ====
# M: start address, then bytes from there up. E: pairs of write address and data
# C: enabled cycles from first fetch to the repeated self-jump fetch, decimal. Rest is hex
M 0010 3C 81 55 0F
M 0200 A9 5A 85 20 A2 C3 86 21 A0 07 84 22 A5 10 A6 11
M 0210 A4 12 85 23 86 24 84 25 09 41 05 13 85 26 29 F3
M 0220 25 12 85 27 49 FF 45 10 85 28 38 69 70 65 11 85
M 0230 29 18 E9 05 E5 13 85 2A 18 69 C0 69 00 85 2B 0A
M 0240 38 2A 4A 6A 85 2C 0A 69 00 85 2D AA E8 86 2E A8
M 0250 88 88 84 2F CA C8 98 85 30 8A 85 31 FF EA 85 32
M 0260 A2 00 CA 86 33 4C 65 02
E 20 5A 21 C3 22 07 23 3C 24 81
E 25 55 26 7F 27 51 28 92 29 85
E 2A 70 2B 31 2C B1 2D 63 2E 64
E 2F 61 30 62 31 63 32 63 33 FF
C 153

// ==== sim.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/cpu_decode.sv
logic/cpu_execute.sv
logic/cpu_result.sv
logic/cpu_top.sv
tb/cpu_bus_model.sv
tb/cpu_tb.sv

// ==== Makefile ====
# Verilator build and run of the CPU testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
RTL_TOP   ?= cpu_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RTL_SRCS  ?= logic/cpu_pkg.sv logic/cpu_decode.sv logic/cpu_execute.sv \
             logic/cpu_result.sv logic/cpu_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "test passed" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall +incdir+logic --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    localparam int timeout_cycles = 1000;  // Clock cycles allowed per run

    logic        clock;
    logic        reset;
    logic        enable;
    logic        stalls;
    logic [7:0]  data_in;
    logic [15:0] address;
    logic [7:0]  data_out;
    logic        write_enable;
    logic        sync;

    logic [15:0] mem_addr_q[$];  // Program image from M lines
    logic [7:0]  mem_data_q[$];
    logic [15:0] exp_addr_q[$];  // Expected writes in bus order
    logic [7:0]  exp_data_q[$];
    int          exp_cycles;
    int          mismatches;
    int          failures;
    bit          ok;

    cpu_top UUT (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_in      (data_in),
        .address      (address),
        .data_out     (data_out),
        .write_enable (write_enable),
        .sync         (sync)
    );

    cpu_bus_model bus (
        .clock        (clock),
        .stalls       (stalls),
        .address      (address),
        .write_data   (data_out),
        .write_enable (write_enable),
        .read_data    (data_in),
        .enable       (enable)
    );

    always #20 clock = ~clock;

    task automatic log_mismatch(input string msg);
        mismatches++;
        $display("Mismatch at time %0t: %s", $time, msg);
    endtask

    task automatic note_failure(input string msg);
        failures++;
        $display("Error at time %0t: %s", $time, msg);
    endtask

    // Token stream, kind letter first, then its numbers
    task automatic read_testdata(output bit loaded);
        int             fd;
        int             value;
        int             kind;       // 1 memory bytes, 2 write pairs, 3 cycle count
        bit             need_addr;  // Next number is an address
        logic [15:0]    at;
        logic [63:0]    tok;
        logic [1023:0]  rest;
        kind       = 0;
        need_addr  = 1'b0;
        at         = '0;
        value      = 0;
        exp_cycles = 0;
        fd = $fopen("tb/cpu_testdata.txt", "r");
        assert (fd != 0)
            else note_failure("cannot open tb/cpu_testdata.txt");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                tok = '0;
                if ($fscanf(fd, "%s", tok) != 1)
                    break;
                if (tok == "#") begin
                    void'($fgets(rest, fd));  // Skip rest of comment line
                end else if (tok == "M" || tok == "E" || tok == "C") begin
                    kind      = (tok == "M") ? 1 : (tok == "E") ? 2 : 3;
                    need_addr = 1'b1;
                end else if (kind == 3) begin
                    void'($sscanf(tok, "%d", value));  // Cycle count is decimal
                    exp_cycles = value;
                end else begin
                    void'($sscanf(tok, "%h", value));
                    if (need_addr) begin
                        at        = value[15:0];
                        need_addr = 1'b0;
                    end else if (kind == 1) begin
                        mem_addr_q.push_back(at);
                        mem_data_q.push_back(value[7:0]);
                        at++;
                    end else begin
                        exp_addr_q.push_back(at);
                        exp_data_q.push_back(value[7:0]);
                        need_addr = 1'b1;  // Pairs repeat
                    end
                end
            end
            $fclose(fd);
        end
        loaded = mem_addr_q.size() > 0 && exp_addr_q.size() > 0 && exp_cycles > 0;
        assert (loaded)
            else note_failure("test data file lacks M, E or C entries");
    endtask

    task automatic load_memory();
        bus.fill_memory();
        foreach (mem_addr_q[i])
            bus.write_byte(mem_addr_q[i], mem_data_q[i]);
    endtask

    task automatic run_program(input logic stall_run, output bit finished);
        int          cycles;
        int          enabled;       // Enabled cycles from the first fetch
        int          writes;
        bit          started;
        bit          done;
        bit          held;          // Last sample was a stalled cycle
        logic [15:0] last_fetch;
        logic [15:0] held_address;
        logic [7:0]  held_data;
        logic        held_we;
        logic        held_sync;
        cycles       = 0;
        enabled      = 0;
        writes       = 0;
        started      = 1'b0;
        done         = 1'b0;
        held         = 1'b0;
        last_fetch   = '0;
        held_address = '0;
        held_data    = '0;
        held_we      = 1'b0;
        held_sync    = 1'b0;
        load_memory();
        @(posedge clock);
        #2;
        reset  = 1'b1;
        stalls = 1'b0;
        repeat (8) begin
            @(negedge clock);
            assert (!sync && !write_enable)
                else log_mismatch($sformatf("sync %b write_enable %b in reset",
                                            sync, write_enable));
            @(posedge clock);
        end
        #2;
        reset  = 1'b0;
        stalls = stall_run;
        while (!done && cycles < timeout_cycles) begin
            @(negedge clock);  // Outputs settled mid-cycle
            cycles++;
            if (held) begin
                assert (address == held_address && data_out == held_data &&
                        write_enable == held_we && sync == held_sync)
                    else log_mismatch("bus outputs changed on a stalled edge");
            end
            held         = !enable;
            held_address = address;
            held_data    = data_out;
            held_we      = write_enable;
            held_sync    = sync;
            if (enable) begin
                if (!started) begin
                    assert (sync && address == 16'h0200)
                        else log_mismatch($sformatf("first cycle sync %b address %h, expected 0200",
                                                    sync, address));
                    started = 1'b1;
                end else if (sync && address == last_fetch) begin
                    done = 1'b1;  // Self-jump fetched again
                end
                if (sync)
                    last_fetch = address;
                if (!done)
                    enabled++;
                if (write_enable) begin
                    assert (writes < exp_addr_q.size())
                        else note_failure("more writes than the test data lists");
                    if (writes < exp_addr_q.size()) begin
                        assert (address == exp_addr_q[writes] && data_out == exp_data_q[writes])
                            else log_mismatch($sformatf("write %0d at %h data %h, expected %h data %h",
                                writes, address, data_out, exp_addr_q[writes], exp_data_q[writes]));
                    end
                    writes++;
                end
            end
        end
        stalls = 1'b0;
        finished = done;
        if (!done) begin
            note_failure($sformatf("self-jump not reached within %0d cycles", timeout_cycles));
        end else begin
            assert (writes == exp_addr_q.size())
                else log_mismatch($sformatf("%0d writes, expected %0d", writes, exp_addr_q.size()));
            assert (enabled == exp_cycles)
                else log_mismatch($sformatf("%0d enabled cycles, expected %0d", enabled, exp_cycles));
        end
    endtask

    initial begin
        clock      = 1'b0;
        reset      = 1'b1;
        stalls     = 1'b0;
        mismatches = 0;
        failures   = 0;
        read_testdata(ok);
        if (ok)
            run_program(1'b0, ok);  // Bus always ready
        if (ok)
            run_program(1'b1, ok);  // Random stalls
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/cpu_bus_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_model (
    input  logic        clock,
    input  logic        stalls,        // Random enable drops on
    input  logic [15:0] address,
    input  logic [7:0]  write_data,
    input  logic        write_enable,
    output logic [7:0]  read_data,
    output logic        enable
);

    logic [7:0]  mem [0:65535];
    logic [31:0] rand_state;
    logic        stall_next;

    // Plain xorshift32 step
    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Byte pattern from the whole address, so stray reads stand out
    task automatic fill_memory();
        int i;
        for (i = 0; i < 65536; i++)
            mem[i] <= i[15:8] ^ i[7:0];
    endtask

    task automatic write_byte(input logic [15:0] at, input logic [7:0] data);
        mem[at] <= data;
    endtask

    initial begin
        enable     = 1'b1;
        rand_state = 32'hbc307efd;
        stall_next = 1'b0;
    end

    assign read_data = mem[address];  // Same-cycle read

    always @(posedge clock) begin
        if (enable && write_enable)
            mem[address] <= write_data;
    end

    // Stall picked at the edge, driven 2 ns later
    always @(posedge clock) begin
        if (stalls)
            rand_state = xorshift(rand_state);
        stall_next = stalls && rand_state[1:0] == 2'b00;  // About one cycle in four
        #2;
        enable = !stall_next;
    end

endmodule

`default_nettype wire

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module cpu_top (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    enable,      // Bus ready, low freezes the core
    input  logic [`CPU_DATA_W-1:0]  data_in,
    output logic [`CPU_ADDR_W-1:0]  address,
    output logic [`CPU_DATA_W-1:0]  data_out,
    output logic                    write_enable,
    output logic                    sync         // Opcode fetch cycle
);

    cpu_pkg::op_t           op;
    cpu_pkg::dest_t         dest;
    cpu_pkg::src_t          src;
    cpu_pkg::src_t          store_src;
    logic [1:0]             shift_kind;
    logic [`CPU_DATA_W-1:0] operand;
    logic                   commit;
    logic                   store;
    logic [`CPU_DATA_W-1:0] a;
    logic [`CPU_DATA_W-1:0] x;
    logic [`CPU_DATA_W-1:0] y;
    logic                   carry;
    logic [`CPU_DATA_W-1:0] value;
    logic                   n;
    logic                   z;
    logic                   c;
    logic                   c_valid;

    // Sequencer and bus address
    cpu_decode u_decode (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_in      (data_in),
        .address      (address),
        .sync         (sync),
        .write_enable (write_enable),
        .op           (op),
        .dest         (dest),
        .src          (src),
        .shift_kind   (shift_kind),
        .operand      (operand),
        .commit       (commit),
        .store        (store),
        .store_src    (store_src)
    );

    cpu_execute u_execute (
        .op         (op),
        .src        (src),
        .shift_kind (shift_kind),
        .operand    (operand),
        .a          (a),
        .x          (x),
        .y          (y),
        .carry      (carry),
        .value      (value),
        .n          (n),
        .z          (z),
        .c          (c),
        .c_valid    (c_valid)
    );

    // Registers and store data
    cpu_result u_result (
        .clock     (clock),
        .reset     (reset),
        .enable    (enable),
        .commit    (commit),
        .dest      (dest),
        .value     (value),
        .n         (n),
        .z         (z),
        .c         (c),
        .c_valid   (c_valid),
        .store     (store),
        .store_src (store_src),
        .a         (a),
        .x         (x),
        .y         (y),
        .carry     (carry),
        .data_out  (data_out)
    );

endmodule

`default_nettype wire

// ==== logic/cpu_result.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module cpu_result (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    enable,
    input  logic                    commit,
    input  cpu_pkg::dest_t          dest,
    input  logic [`CPU_DATA_W-1:0]  value,
    input  logic                    n,
    input  logic                    z,
    input  logic                    c,
    input  logic                    c_valid,
    input  logic                    store,
    input  cpu_pkg::src_t           store_src,
    output logic [`CPU_DATA_W-1:0]  a,
    output logic [`CPU_DATA_W-1:0]  x,
    output logic [`CPU_DATA_W-1:0]  y,
    output logic                    carry,
    output logic [`CPU_DATA_W-1:0]  data_out
);

    // Architectural state, written at the end of the last cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            a      <= '0;
            x      <= '0;
            y      <= '0;
            carry  <= 1'b0;
        end else if (enable && commit) begin
            case (dest)
                cpu_pkg::dest_a: a <= value;
                cpu_pkg::dest_x: x <= value;
                cpu_pkg::dest_y: y <= value;
                default: ;
            endcase
            if (c_valid)
                carry <= c;
        end
    end

    // Store data, zero when not writing
    always_comb begin
        data_out = '0;
        if (store) begin
            case (store_src)
                cpu_pkg::src_a: data_out = a;
                cpu_pkg::src_x: data_out = x;
                cpu_pkg::src_y: data_out = y;
                default:        data_out = '0;
            endcase
        end
    end

    a_store_no_dest: assert property (@(posedge clock) disable iff (reset)
        store |-> dest == cpu_pkg::dest_none)
        else $error("store cycle also writes a register");

endmodule

`default_nettype wire

// ==== logic/cpu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module cpu_execute (
    input  cpu_pkg::op_t            op,
    input  cpu_pkg::src_t           src,
    input  logic [1:0]              shift_kind,
    input  logic [`CPU_DATA_W-1:0]  operand,
    input  logic [`CPU_DATA_W-1:0]  a,
    input  logic [`CPU_DATA_W-1:0]  x,
    input  logic [`CPU_DATA_W-1:0]  y,
    input  logic                    carry,
    output logic [`CPU_DATA_W-1:0]  value,
    output logic                    n,
    output logic                    z,
    output logic                    c,
    output logic                    c_valid
);

    localparam logic [`CPU_DATA_W-1:0] byte_one = 1;

    logic [`CPU_DATA_W-1:0] opnd;
    logic [`CPU_DATA_W-1:0] addend;  // Complemented for SBC
    logic [`CPU_DATA_W:0]   sum;     // Carry out on top
    logic                   shift_in;

    // Operand select
    always_comb begin
        case (src)
            cpu_pkg::src_a: opnd = a;
            cpu_pkg::src_x: opnd = x;
            cpu_pkg::src_y: opnd = y;
            default:        opnd = operand;
        endcase
    end

    assign addend   = (op == cpu_pkg::op_sbc) ? ~opnd : opnd;
    assign sum      = {1'b0, a} + {1'b0, addend} + {{`CPU_DATA_W{1'b0}}, carry};
    assign shift_in = carry & shift_kind[0];  // ROL/ROR pull in carry

    always_comb begin
        value = '0;
        c     = carry;
        case (op)
            cpu_pkg::op_load,
            cpu_pkg::op_transfer:    value = opnd;
            cpu_pkg::op_ora:         value = a | opnd;
            cpu_pkg::op_and:         value = a & opnd;
            cpu_pkg::op_eor:         value = a ^ opnd;
            cpu_pkg::op_adc,
            cpu_pkg::op_sbc:         {c, value} = sum;  // Binary only
            cpu_pkg::op_shift: begin
                if (shift_kind[1])
                    {value, c} = {shift_in, opnd};  // LSR/ROR
                else
                    {c, value} = {opnd, shift_in};  // ASL/ROL
            end
            cpu_pkg::op_increment:   value = opnd + byte_one;
            cpu_pkg::op_decrement:   value = opnd - byte_one;
            cpu_pkg::op_set_carry:   c = 1'b1;
            cpu_pkg::op_clear_carry: c = 1'b0;
            default: ;
        endcase
        c_valid = op inside {cpu_pkg::op_adc, cpu_pkg::op_sbc, cpu_pkg::op_shift,
                             cpu_pkg::op_set_carry, cpu_pkg::op_clear_carry};
    end

    assign n = value[`CPU_DATA_W-1];
    assign z = (value == '0);

endmodule

`default_nettype wire

// ==== logic/cpu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module cpu_decode (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    enable,
    input  logic [`CPU_DATA_W-1:0]  data_in,
    output logic [`CPU_ADDR_W-1:0]  address,
    output logic                    sync,
    output logic                    write_enable,
    output cpu_pkg::op_t            op,
    output cpu_pkg::dest_t          dest,
    output cpu_pkg::src_t           src,
    output logic [1:0]              shift_kind,
    output logic [`CPU_DATA_W-1:0]  operand,
    output logic                    commit,
    output logic                    store,
    output cpu_pkg::src_t           store_src
);

    logic [`CPU_DATA_W-1:0] opcode_q;   // Current opcode
    logic [`CPU_DATA_W-1:0] operand_q;  // Zero-page address or JMP low byte
    logic [`CPU_ADDR_W-1:0] pc;
    cpu_pkg::phase_t        phase;
    cpu_pkg::phase_t        next_phase;

    // Opcode fields aaa_bbb_cc
    logic [2:0] op_aaa;
    logic [2:0] op_bbb;
    logic [1:0] op_cc;

    cpu_pkg::op_t   dec_op;
    cpu_pkg::dest_t dec_dest;
    cpu_pkg::src_t  dec_src;
    cpu_pkg::src_t  dec_store_src;
    cpu_pkg::dest_t ls_dest;  // Load/store register by cc
    cpu_pkg::src_t  ls_src;
    logic dec_imm;            // Two bytes, PC advances on operand
    logic dec_zp;             // Three cycles, zero page
    logic dec_jmp;
    logic dec_store;
    logic mode_imm;
    logic mode_zp;
    logic exec_cycle;         // Last cycle of the instruction
    logic pc_step;
    logic pc_jump;

    assign op_aaa = opcode_q[7:5];
    assign op_bbb = opcode_q[4:2];
    assign op_cc  = opcode_q[1:0];

    // Zero page is bbb 001 in every group, immediate moves with the group
    assign mode_zp  = (op_bbb == 3'b001);
    assign mode_imm = (op_cc == 2'b01) ? (op_bbb == 3'b010) : (op_bbb == 3'b000);

    // cc picks the register of LDx/STx: 00 Y, 01 A, 10 X
    always_comb begin
        case (op_cc)
            2'b00: begin
                ls_src  = cpu_pkg::src_y;
                ls_dest = cpu_pkg::dest_y;
            end
            2'b10: begin
                ls_src  = cpu_pkg::src_x;
                ls_dest = cpu_pkg::dest_x;
            end
            default: begin
                ls_src  = cpu_pkg::src_a;
                ls_dest = cpu_pkg::dest_a;
            end
        endcase
    end

    // Opcode decode, anything unmatched stays a two-cycle NOP
    always_comb begin
        dec_op        = cpu_pkg::op_none;
        dec_dest      = cpu_pkg::dest_none;
        dec_src       = cpu_pkg::src_data;
        dec_store_src = ls_src;
        dec_store     = 1'b0;
        dec_imm       = 1'b0;
        dec_zp        = 1'b0;
        dec_jmp       = 1'b0;
        case ({op_cc, op_bbb})
            5'b10_010: begin  // ASL ROL LSR ROR TXA TAX DEX NOP
                case (op_aaa)
                    3'b100: begin
                        dec_op   = cpu_pkg::op_transfer;
                        dec_dest = cpu_pkg::dest_a;
                        dec_src  = cpu_pkg::src_x;
                    end
                    3'b101: begin
                        dec_op   = cpu_pkg::op_transfer;
                        dec_dest = cpu_pkg::dest_x;
                        dec_src  = cpu_pkg::src_a;
                    end
                    3'b110: begin
                        dec_op   = cpu_pkg::op_decrement;
                        dec_dest = cpu_pkg::dest_x;
                        dec_src  = cpu_pkg::src_x;
                    end
                    3'b111: ;  // NOP
                    default: begin
                        dec_op   = cpu_pkg::op_shift;
                        dec_dest = cpu_pkg::dest_a;
                        dec_src  = cpu_pkg::src_a;
                    end
                endcase
            end
            5'b00_010: begin  // DEY TAY INY INX, stack ops fall out
                dec_dest = op_aaa[0] & op_aaa[1] ? cpu_pkg::dest_x : cpu_pkg::dest_y;
                dec_src  = op_aaa == 3'b101 ? cpu_pkg::src_a
                         : op_aaa == 3'b111 ? cpu_pkg::src_x : cpu_pkg::src_y;
                case (op_aaa)
                    3'b100:  dec_op = cpu_pkg::op_decrement;
                    3'b101:  dec_op = cpu_pkg::op_transfer;
                    3'b110,
                    3'b111:  dec_op = cpu_pkg::op_increment;
                    default: dec_dest = cpu_pkg::dest_none;
                endcase
            end
            5'b00_110: begin  // CLC SEC TYA
                case (op_aaa)
                    3'b000: dec_op = cpu_pkg::op_clear_carry;
                    3'b001: dec_op = cpu_pkg::op_set_carry;
                    3'b100: begin
                        dec_op   = cpu_pkg::op_transfer;
                        dec_dest = cpu_pkg::dest_a;
                        dec_src  = cpu_pkg::src_y;
                    end
                    default: ;
                endcase
            end
            5'b00_011: dec_jmp = (op_aaa == 3'b010);  // JMP abs only
            default: begin
                if (op_cc != 2'b11 && (mode_zp || mode_imm)) begin
                    if (op_aaa == 3'b101) begin  // LDA LDX LDY
                        dec_op   = cpu_pkg::op_load;
                        dec_dest = ls_dest;
                    end else if (op_aaa == 3'b100) begin
                        dec_store = mode_zp;  // STA/STX/STY zero page
                    end else if (op_cc == 2'b01) begin
                        dec_dest = cpu_pkg::dest_a;
                        case (op_aaa)
                            3'b000:  dec_op = cpu_pkg::op_ora;
                            3'b001:  dec_op = cpu_pkg::op_and;
                            3'b010:  dec_op = cpu_pkg::op_eor;
                            3'b011:  dec_op = cpu_pkg::op_adc;
                            3'b111:  dec_op = cpu_pkg::op_sbc;
                            default: dec_dest = cpu_pkg::dest_none;  // CMP
                        endcase
                    end
                    dec_imm = mode_imm && dec_op != cpu_pkg::op_none;
                    dec_zp  = mode_zp && (dec_op != cpu_pkg::op_none || dec_store);
                end
            end
        endcase
    end

    // Phase sequencer
    always_comb begin
        next_phase = cpu_pkg::ph_fetch;
        exec_cycle = 1'b0;
        pc_step    = 1'b0;
        pc_jump    = 1'b0;
        case (phase)
            cpu_pkg::ph_fetch: begin
                next_phase = cpu_pkg::ph_operand;
                pc_step    = 1'b1;
            end
            cpu_pkg::ph_operand: begin
                pc_step = dec_imm | dec_zp | dec_jmp;  // Implied leaves PC alone
                if (dec_zp)
                    next_phase = cpu_pkg::ph_zero_page;
                else if (dec_jmp)
                    next_phase = cpu_pkg::ph_address_high;
                else
                    exec_cycle = 1'b1;
            end
            cpu_pkg::ph_zero_page: exec_cycle = 1'b1;
            default:               pc_jump = 1'b1;  // Address high
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            phase    <= cpu_pkg::ph_fetch;
            pc       <= `CPU_RESET_PC;
            opcode_q <= 8'hea;  // NOP
        end else if (enable) begin
            phase <= next_phase;
            if (phase == cpu_pkg::ph_fetch)
                opcode_q <= data_in;
            if (pc_jump)
                pc <= {data_in, operand_q};
            else if (pc_step)
                pc <= pc + 1'b1;
        end
    end

    // Byte after the opcode, kept for zero page and JMP
    always_ff @(posedge clock) begin
        if (enable && phase == cpu_pkg::ph_operand)
            operand_q <= data_in;
    end

    assign address      = (phase == cpu_pkg::ph_zero_page) ? {`CPU_ZP_HIGH, operand_q} : pc;
    assign sync         = (phase == cpu_pkg::ph_fetch) & ~reset;  // Low while held in reset
    assign store        = dec_store & (phase == cpu_pkg::ph_zero_page);
    assign write_enable = store;
    assign store_src    = dec_store_src;
    assign op           = exec_cycle ? dec_op : cpu_pkg::op_none;
    assign dest         = exec_cycle ? dec_dest : cpu_pkg::dest_none;
    assign src          = dec_src;
    assign shift_kind   = opcode_q[6:5];  // Right in bit 1, rotate in bit 0
    assign operand      = data_in;
    assign commit       = exec_cycle && dec_op != cpu_pkg::op_none;

    // A store is the last cycle of its instruction
    a_write_last: assert property (@(posedge clock) disable iff (reset)
        enable && write_enable |=> sync)
        else $error("store cycle not followed by an opcode fetch");

    // Operand cycle reads the byte right after the opcode
    a_fetch_step: assert property (@(posedge clock) disable iff (reset)
        enable && sync |=> address == $past(address) + 1'b1)
        else $error("operand read not at the byte after the opcode");

    a_address_known: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(address))
        else $error("bus address unknown");

endmodule

`default_nettype wire

// ==== logic/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // Bus cycle the decoder is running
    typedef enum logic [1:0] {
        ph_fetch,         // Opcode read, sync high
        ph_operand,       // Byte after the opcode
        ph_address_high,  // JMP target high byte
        ph_zero_page      // Zero-page read or write
    } phase_t;

    // Execute operation
    typedef enum logic [3:0] {
        op_none,
        op_load,
        op_ora,
        op_and,
        op_eor,
        op_adc,
        op_sbc,
        op_shift,         // ASL ROL LSR ROR on A
        op_transfer,
        op_increment,
        op_decrement,
        op_set_carry,
        op_clear_carry
    } op_t;

    // Register written on commit
    typedef enum logic [1:0] {
        dest_none,
        dest_a,
        dest_x,
        dest_y
    } dest_t;

    // Operand source
    typedef enum logic [1:0] {
        src_a,
        src_x,
        src_y,
        src_data          // Live bus byte
    } src_t;

endpackage

`default_nettype wire

// ==== logic/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Bus widths
`define CPU_DATA_W 8   // Data bus, one byte
`define CPU_ADDR_W 16  // Address bus, two bytes

// First opcode fetch after reset, no vector fetch
`define CPU_RESET_PC 16'h0200

// High address byte on zero-page cycles
`define CPU_ZP_HIGH 8'h00

`endif
